//--- logic/z80_bus_pkg.sv
package z80_bus_pkg;

    ////////////////////////////////
    // Z80 bus widths
    ////////////////////////////////

    // Full 16-bit address bus
    typedef logic [15:0] addr_t;

    // Data byte, both directions
    typedef logic [7:0] data_t;

    // IO cycles only decode the low address byte
    typedef logic [7:0] io_port_t;

    // Eight rows of eight keys, row n in bits 8n+7..8n
    // A zero bit means the key is down
    typedef logic [63:0] key_matrix_t;

    ////////////////////////////////
    // Strobe synchronizer
    ////////////////////////////////

    // Needs at least two stages for edge detection
    localparam int SYNC_STAGES_DEFAULT = 3;

endpackage

//--- logic/memory_map_pkg.sv
package memory_map_pkg;

    import z80_bus_pkg::*;

    ////////////////////////////////
    // Memory paging
    ////////////////////////////////

    typedef logic [5:0] page_t;       // 64 pages of 16KB
    typedef logic [4:0] bank_addr_t;  // A18..A14 of the external chips

    // Bit 7 read-only, bit 6 overlay enable, bits 5..0 page
    typedef logic [7:0] bank_reg_t;

    // Pages 0-15 live in the ROM, 32-63 in the RAM
    // System RAM sits in page 32 and backs the $3800-$3FFF overlay
    localparam page_t SYSRAM_PAGE = 6'd32;

    ////////////////////////////////
    // IO ports
    ////////////////////////////////

    localparam io_port_t PORT_BANK0    = 8'hF0;
    localparam io_port_t PORT_BANK1    = 8'hF1;
    localparam io_port_t PORT_BANK2    = 8'hF2;
    localparam io_port_t PORT_BANK3    = 8'hF3;
    localparam io_port_t PORT_CASSETTE = 8'hFC;
    localparam io_port_t PORT_PRINTER  = 8'hFE;
    localparam io_port_t PORT_KEYBOARD = 8'hFF;  // Read only

    // Bank defaults after reset
    localparam bank_reg_t BANK0_RESET = 8'hC0;  // ROM page 0, read-only, overlay on
    localparam bank_reg_t BANK1_RESET = 8'h21;  // RAM page 33
    localparam bank_reg_t BANK2_RESET = 8'h22;  // RAM page 34
    localparam bank_reg_t BANK3_RESET = 8'h13;  // Page 19, no chip behind it

endpackage

//--- logic/bus_strobe_sync.sv
`timescale 1ns/1ns

module bus_strobe_sync import z80_bus_pkg::*; #(
    parameter int SYNC_STAGES = SYNC_STAGES_DEFAULT
) (
    input  logic  sysclk,
    input  logic  reset,
    input  logic  rd_n,
    input  logic  wr_n,
    input  data_t d_in,
    output logic  bus_read,
    output logic  bus_write,
    output data_t wr_data
);

    logic [SYNC_STAGES-1:0] rd_n_sync;  // Bit 0 is the newest sample
    logic [SYNC_STAGES-1:0] wr_n_sync;
    logic                   rd_fall;
    logic                   wr_fall;

    // Falling edge seen between the two oldest stages
    assign rd_fall = rd_n_sync[SYNC_STAGES-1] && !rd_n_sync[SYNC_STAGES-2];
    assign wr_fall = wr_n_sync[SYNC_STAGES-1] && !wr_n_sync[SYNC_STAGES-2];

    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            rd_n_sync <= '1;  // Strobes idle high
            wr_n_sync <= '1;
            bus_read  <= 1'b0;
            bus_write <= 1'b0;
        end else begin
            rd_n_sync <= {rd_n_sync[SYNC_STAGES-2:0], rd_n};
            wr_n_sync <= {wr_n_sync[SYNC_STAGES-2:0], wr_n};
            bus_read  <= rd_fall;  // One pulse per strobe
            bus_write <= wr_fall;
        end
    end

    // Data is stable for the whole low phase of wr_n,
    // so the raw pins are safe to sample here
    always_ff @(posedge sysclk) begin
        if (!wr_n) begin
            wr_data <= d_in;
        end
    end

endmodule

//--- logic/bank_mapper.sv
`timescale 1ns/1ns

module bank_mapper import z80_bus_pkg::*, memory_map_pkg::*; (
    input  logic       sysclk,
    input  logic       reset,
    input  addr_t      a,
    input  logic       mreq_n,
    input  logic       iorq_n,
    input  logic       wr_n,
    input  logic       bus_write,
    input  data_t      wr_data,
    output logic       rom_ce_n,
    output logic       ram_ce_n,
    output bank_addr_t ba,
    output logic       bank_sel,
    output data_t      bank_rddata
);

    localparam io_port_t BANK_PORT [4] = '{PORT_BANK0, PORT_BANK1, PORT_BANK2, PORT_BANK3};
    localparam bank_reg_t BANK_RESET [4] = '{BANK0_RESET, BANK1_RESET, BANK2_RESET, BANK3_RESET};

    bank_reg_t  bank_regs [4];
    logic [3:0] port_hit;
    io_port_t   io_port;

    bank_reg_t  cur_bank;     // Bank behind the current address
    page_t      cur_page;
    logic       cur_ro;
    logic       cur_overlay;
    logic       sel_sysram;
    logic       allow_mem;
    logic       sel_rom;
    logic       sel_ram;

    ////////////////////////////////
    // Bank registers, IO $F0-$F3
    ////////////////////////////////

    assign io_port = a[7:0];

    always_comb begin
        bank_rddata = 8'h00;
        for (int i = 0; i < 4; i++) begin
            port_hit[i] = !iorq_n && (io_port == BANK_PORT[i]);
            if (port_hit[i]) bank_rddata = bank_regs[i];
        end
    end

    assign bank_sel = |port_hit;

    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                bank_regs[i] <= BANK_RESET[i];
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (bus_write && port_hit[i]) bank_regs[i] <= wr_data;
            end
        end
    end

    ////////////////////////////////
    // Memory decode
    ////////////////////////////////

    assign cur_bank    = bank_regs[a[15:14]];  // One bank per 16KB quarter
    assign cur_page    = cur_bank[5:0];
    assign cur_ro      = cur_bank[7];
    assign cur_overlay = cur_bank[6];

    // $3800-$3FFF within the quarter, ignores the read-only flag
    assign sel_sysram = !mreq_n && cur_overlay && (a[13:11] == 3'b111);

    // Writes into a read-only bank are dropped
    assign allow_mem = !mreq_n && !sel_sysram && (wr_n || !cur_ro);

    assign sel_rom = allow_mem && (cur_page[5:4] == 2'b00);       // Pages 0-15
    assign sel_ram = (allow_mem && (cur_page >= SYSRAM_PAGE)) || sel_sysram;

    assign rom_ce_n = !sel_rom;
    assign ram_ce_n = !sel_ram;
    assign ba       = sel_sysram ? bank_addr_t'(SYSRAM_PAGE) : cur_page[4:0];

endmodule

//--- logic/io_port_regs.sv
`timescale 1ns/1ns

module io_port_regs import z80_bus_pkg::*, memory_map_pkg::*; (
    input  logic        sysclk,
    input  logic        reset,
    input  addr_t       a,
    input  logic        iorq_n,
    input  logic        rd_n,
    input  logic        bus_write,
    input  data_t       wr_data,
    input  key_matrix_t keys,
    input  logic        cassette_in,
    input  logic        printer_in,
    input  logic        bank_sel,
    input  data_t       bank_rddata,
    output logic        cassette_out,
    output logic        printer_out,
    output data_t       d_out,
    output logic        d_oe
);

    io_port_t io_port;
    logic     sel_cassette;
    logic     sel_printer;
    logic     sel_keyboard;
    data_t    key_rddata;

    ////////////////////////////////
    // Port decode
    ////////////////////////////////

    assign io_port      = a[7:0];
    assign sel_cassette = !iorq_n && (io_port == PORT_CASSETTE);
    assign sel_printer  = !iorq_n && (io_port == PORT_PRINTER);
    assign sel_keyboard = !iorq_n && (io_port == PORT_KEYBOARD);

    ////////////////////////////////
    // Output latches
    ////////////////////////////////

    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            cassette_out <= 1'b0;
            printer_out  <= 1'b0;
        end else if (bus_write) begin
            if (sel_cassette) cassette_out <= wr_data[0];
            if (sel_printer) printer_out <= wr_data[0];
        end
    end

    ////////////////////////////////
    // Keyboard matrix
    ////////////////////////////////

    // Upper address byte picks rows, active low
    // Pressed keys pull their column to zero
    always_comb begin
        key_rddata = 8'hFF;  // No row selected
        for (int row = 0; row < 8; row++) begin
            if (!a[row + 8]) key_rddata &= keys[row*8 +: 8];
        end
    end

    ////////////////////////////////
    // Read data return
    ////////////////////////////////

    always_comb begin
        d_out = 8'h00;
        if (sel_cassette) d_out = {7'b0, cassette_in};
        if (sel_printer) d_out = {7'b0, printer_in};
        if (sel_keyboard) d_out = key_rddata;
        if (bank_sel) d_out = bank_rddata;  // $F0-$F3
    end

    // Only drive the bus for ports decoded in this design
    assign d_oe = !rd_n && (sel_cassette || sel_printer || sel_keyboard || bank_sel);

endmodule

//--- logic/expansion_bus_top.sv
`timescale 1ns/1ns

module expansion_bus_top import z80_bus_pkg::*, memory_map_pkg::*; #(
    parameter int SYNC_STAGES = SYNC_STAGES_DEFAULT
) (
    input  logic        sysclk,
    input  logic        reset,

    // Z80 bus
    input  addr_t       a,
    input  data_t       d_in,
    output data_t       d_out,
    output logic        d_oe,      // Enables d_out onto the bus
    input  logic        rd_n,
    input  logic        wr_n,
    input  logic        mreq_n,
    input  logic        iorq_n,

    // Memory chips
    output logic        rom_ce_n,
    output logic        ram_ce_n,
    output bank_addr_t  ba,

    // Peripherals
    input  key_matrix_t keys,
    input  logic        cassette_in,
    output logic        cassette_out,
    input  logic        printer_in,
    output logic        printer_out
);

    logic  bus_read;     // No read side effects in these ports
    logic  bus_write;
    data_t wr_data;
    logic  bank_sel;
    data_t bank_rddata;

    bus_strobe_sync #(
        .SYNC_STAGES(SYNC_STAGES)
    ) i_bus_strobe_sync (
        .sysclk    (sysclk),
        .reset     (reset),
        .rd_n      (rd_n),
        .wr_n      (wr_n),
        .d_in      (d_in),
        .bus_read  (bus_read),
        .bus_write (bus_write),
        .wr_data   (wr_data)
    );

    bank_mapper i_bank_mapper (
        .sysclk      (sysclk),
        .reset       (reset),
        .a           (a),
        .mreq_n      (mreq_n),
        .iorq_n      (iorq_n),
        .wr_n        (wr_n),
        .bus_write   (bus_write),
        .wr_data     (wr_data),
        .rom_ce_n    (rom_ce_n),
        .ram_ce_n    (ram_ce_n),
        .ba          (ba),
        .bank_sel    (bank_sel),
        .bank_rddata (bank_rddata)
    );

    io_port_regs i_io_port_regs (
        .sysclk       (sysclk),
        .reset        (reset),
        .a            (a),
        .iorq_n       (iorq_n),
        .rd_n         (rd_n),
        .bus_write    (bus_write),
        .wr_data      (wr_data),
        .keys         (keys),
        .cassette_in  (cassette_in),
        .printer_in   (printer_in),
        .bank_sel     (bank_sel),
        .bank_rddata  (bank_rddata),
        .cassette_out (cassette_out),
        .printer_out  (printer_out),
        .d_out        (d_out),
        .d_oe         (d_oe)
    );

endmodule

//--- verification/expansion_bus_asserts.sv
`timescale 1ns/1ns

module expansion_bus_asserts (
    input logic sysclk,
    input logic reset,
    input logic rd_n,
    input logic rom_ce_n,
    input logic ram_ce_n,
    input logic d_oe,
    input logic bus_write
);

    // One memory chip at a time
    chip_select_exclusive: assert property (@(posedge sysclk) disable iff (reset)
        !(!rom_ce_n && !ram_ce_n)
    ) else $error("ROM and RAM chip selects active together");

    data_enable_on_read: assert property (@(posedge sysclk) disable iff (reset)
        !(d_oe && rd_n)  // Bus driven only inside a read
    ) else $error("d_oe high while rd_n is high");

    write_pulse_single: assert property (@(posedge sysclk) disable iff (reset)
        bus_write |=> !bus_write
    ) else $error("bus_write held for two cycles");

endmodule

//--- verification/expansion_bus_tb.sv
`timescale 1ns/1ns

module expansion_bus_tb import z80_bus_pkg::*, memory_map_pkg::*;;

    logic        sysclk;
    logic        reset;
    addr_t       a;
    data_t       d_in;
    data_t       d_out;
    logic        d_oe;
    logic        rd_n;
    logic        wr_n;
    logic        mreq_n;
    logic        iorq_n;
    logic        rom_ce_n;
    logic        ram_ce_n;
    bank_addr_t  ba;
    key_matrix_t keys;
    logic        cassette_in;
    logic        cassette_out;
    logic        printer_in;
    logic        printer_out;

    logic [15:0] stim [0:255];  // Four words per operation
    int          errors;
    int          op;
    int          kind;
    addr_t       op_addr;
    logic [15:0] expect_val;
    data_t       key_val;
    string       name;

    expansion_bus_top #(.SYNC_STAGES(SYNC_STAGES_DEFAULT)) i_expansion_bus_top (.*);

    bind expansion_bus_top expansion_bus_asserts i_expansion_bus_asserts (
        .sysclk    (sysclk),
        .reset     (reset),
        .rd_n      (rd_n),
        .rom_ce_n  (rom_ce_n),
        .ram_ce_n  (ram_ce_n),
        .d_oe      (d_oe),
        .bus_write (bus_write)
    );

    always #4 sysclk = ~sysclk;

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic report_mismatch(input string test, input logic [15:0] exp,
                                   input logic [15:0] act);
        errors++;
        $display("Mismatch %s: expected %h, actual %h", test, exp, act);
    endtask

    // AND of every row whose select bit is low
    function automatic data_t expected_keys(input key_matrix_t k, input logic [7:0] rows_n);
        data_t v;
        v = 8'hFF;
        for (int r = 0; r < 8; r++) begin
            if (!rows_n[r]) v = v & k[r*8 +: 8];
        end
        return v;
    endfunction

    // Opens a bus cycle and holds it until one clock past the register update
    task automatic bus_cycle(input int k, input addr_t addr, input data_t data,
                             input string test);
        int  waited;
        bit  is_write;
        logic pulse;
        is_write = (k == 1) || (k == 4);
        @(posedge sysclk);
        a      <= addr;
        d_in   <= data;
        iorq_n <= !((k == 1) || (k == 2) || (k == 5));
        mreq_n <= !((k == 3) || (k == 4));
        wr_n   <= !is_write;
        rd_n   <= is_write;
        if (k == 2) begin
            cassette_in <= data[0];
            printer_in  <= data[1];
        end
        if (k == 5) keys <= {$urandom(), $urandom()};
        waited = 0;
        do begin
            @(negedge sysclk);
            waited++;
            pulse = is_write ? i_expansion_bus_top.bus_write : i_expansion_bus_top.bus_read;
        end while (pulse !== 1'b1 && waited < 12);
        if (pulse !== 1'b1) begin
            errors++;
            $display("Timeout in %s: no strobe pulse after %0d cycles", test, waited);
        end
        @(posedge sysclk);  // Register update
        @(posedge sysclk);
        @(negedge sysclk);
    endtask

    task automatic end_cycle();
        @(posedge sysclk);
        rd_n   <= 1'b1;
        wr_n   <= 1'b1;
        mreq_n <= 1'b1;
        iorq_n <= 1'b1;
        repeat (2) @(posedge sysclk);
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        sysclk      = 1'b0;
        reset       = 1'b1;
        a           = '0;
        d_in        = '0;
        rd_n        = 1'b1;
        wr_n        = 1'b1;
        mreq_n      = 1'b1;
        iorq_n      = 1'b1;
        keys        = '1;  // No key down
        cassette_in = 1'b0;
        printer_in  = 1'b0;
        errors      = 0;
        void'($urandom(86612));
        $readmemh("verification/bus_stimulus.txt", stim);
        repeat (16) @(posedge sysclk);
        reset <= 1'b0;

        op = 0;
        while (op < 64 && stim[op*4] >= 1 && stim[op*4] <= 5) begin
            kind       = stim[op*4];
            op_addr    = stim[op*4+1];
            expect_val = stim[op*4+3];
            name       = $sformatf("op%0d_kind%0d_%h", op, kind, op_addr);
            bus_cycle(kind, op_addr, stim[op*4+2][7:0], name);
            case (kind)
                1: if ({printer_out, cassette_out} !== expect_val[1:0])
                    report_mismatch(name, expect_val[1:0], {printer_out, cassette_out});
                2: if ({d_oe, d_out} !== expect_val[8:0])
                    report_mismatch(name, expect_val[8:0], {d_oe, d_out});
                3, 4: begin
                    if ({rom_ce_n, ram_ce_n} !== expect_val[1:0])
                        report_mismatch(name, expect_val[1:0], {rom_ce_n, ram_ce_n});
                    if ((!rom_ce_n || !ram_ce_n) && ba !== expect_val[8:4])
                        report_mismatch({name, "_ba"}, expect_val[8:4], ba);
                    if (d_oe !== 1'b0) report_mismatch({name, "_oe"}, 16'h0, d_oe);
                end
                default: begin
                    key_val = expected_keys(keys, op_addr[15:8]);
                    if ({d_oe, d_out} !== {1'b1, key_val})
                        report_mismatch(name, {1'b1, key_val}, {d_oe, d_out});
                end
            endcase
            end_cycle();
            op++;
        end
        if (op < 10) begin
            errors++;
            $display("Stimulus file missing or too short, %0d operations run", op);
        end

        $display("Operations: %0d  Errors: %0d", op, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- verification/bus_stimulus.txt
// kind addr data expected, kind 1 io wr, 2 io rd, 3 mem rd, 4 mem wr, 5 key rd, F end
// io rd expected {d_oe,d_out}, mem expected ba byte then {rom_ce_n,ram_ce_n}, io wr {prn,cas}
2 00F0 00 1C0
2 00F1 00 121
2 00F2 00 122
2 00F3 00 113
3 0000 00 001
3 4000 00 012
3 C000 00 133
3 3800 00 002
4 1000 00 003
3 1000 00 001
1 00F1 05 000
2 00F1 00 105
4 4000 00 051
1 00F2 3F 000
3 8123 00 1F2
1 00F3 18 000
3 C000 00 183
1 00F2 A0 000
2 00F2 00 1A0
3 8000 00 002
4 8000 00 003
1 00FC 01 001
1 00FE 01 003
1 00FC 00 002
2 00FC 01 101
2 00FE 02 101
2 0080 00 000
5 FEFF 00 000
5 00FF 00 000
5 5AFF 00 000
5 FFFF 00 000
F 0000 00 000

//--- vlog.f
logic/z80_bus_pkg.sv
logic/memory_map_pkg.sv
logic/bus_strobe_sync.sv
logic/bank_mapper.sv
logic/io_port_regs.sv
logic/expansion_bus_top.sv
verification/expansion_bus_asserts.sv
verification/expansion_bus_tb.sv

//--- Bender.yml
package:
  name: expansion_bus

sources:
  - logic/z80_bus_pkg.sv
  - logic/memory_map_pkg.sv
  - logic/bus_strobe_sync.sv
  - logic/bank_mapper.sv
  - logic/io_port_regs.sv
  - logic/expansion_bus_top.sv
  - target: test
    files:
      - verification/expansion_bus_asserts.sv
      - verification/expansion_bus_tb.sv
